/* Bender.yml */
package:
  name: cart_loader

sources:
  # Packages first, then the RTL bottom up
  - files:
      - rtl/loader_pkg.sv
      - rtl/mapper_pkg.sv
      - rtl/cart_header_scan.sv
      - rtl/rom_size_track.sv
      - rtl/bank_mapper.sv
      - rtl/cart_loader_top.sv

  - target: test
    files:
      - tests/tb_cart_loader.sv

/* rtl/bank_mapper.sv */
//////////////////////////////////////////////////////////////////////
// Bank registers behind the time/page port and CPU to ROM translation.
// Large-ROM banking only works once the mask shows an image over 4 MB.
// Registers return to the identity map while a ROM is loading.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module bank_mapper import loader_pkg::*, mapper_pkg::*; #(
	parameter int NUM_BANKS    = 8,
	parameter int BANK_SEL_LSB = 19
) (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  page_wr_t  page,
	input  rom_addr_t cpu_va,
	input  rom_mask_t rom_mask,
	input  logic      pier_quirk,
	input  logic      rom_loading,
	output rom_addr_t rom_va
);

	localparam int SEL_W = $clog2(NUM_BANKS);

	bank_t             bank_reg [NUM_BANKS];
	logic              page_wr;
	logic              large_rom;
	logic              pier_hit;
	logic [SEL_W-1:0]  pier_sel;
	logic [SEL_W-1:0]  cpu_sel;
	rom_addr_t         raw_va;

	assign page_wr   = page.strobe & ~page.rnw;
	assign large_rom = rom_mask[MASK_HI] | rom_mask[MASK_HI-1];

	// Pier boards use offsets 1..3 for the upper banks
	assign pier_hit = (page.va != 3'd0) && (page.va < PAGE_PIER_EEPROM);
	assign pier_sel = SEL_W'(NUM_BANKS / 2) + SEL_W'(page.va);

	//////////////////////////////////////////////////////////////////////
	// Page-port writes

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int n = 0; n < NUM_BANKS; n++)
				bank_reg[n] <= bank_t'(n);
		end else if (rom_loading) begin
			for (int n = 0; n < NUM_BANKS; n++)
				bank_reg[n] <= bank_t'(n); // Identity map
		end else if (page_wr) begin
			if (pier_quirk) begin
				if (pier_hit)
					bank_reg[pier_sel] <= bank_t'(page.wdata[PIER_FIELD_W-1:0]);
			end else if (large_rom && page.va != 3'd0) begin
				bank_reg[SEL_W'(page.va)] <= page.wdata[BANK_FIELD_W-1:0];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Address translation

	assign cpu_sel = cpu_va[BANK_SEL_LSB+SEL_W-1:BANK_SEL_LSB];
	assign raw_va  = {bank_reg[cpu_sel], cpu_va[BANK_SEL_LSB-1:1]};

	// Bits 12..1 always pass through
	assign rom_va = raw_va & {rom_mask, {(MASK_LO - 1){1'b1}}};

endmodule

/* rtl/cart_header_scan.sv */
//////////////////////////////////////////////////////////////////////
// Watches a ROM download for the region byte and the product ID.
// region_set only pulses high during a download with auto_region on.
// ID capture needs the cartridge bit of the file index.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cart_header_scan import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  dl_stream_t dl,
	input  logic       auto_region,
	output region_t    region_req,
	output logic       region_set,
	output logic       pier_quirk
);

	logic        rom_active;
	logic        rom_active_q;
	logic        dl_start;
	logic        dl_done;
	logic        rom_wr;
	logic        id_wr;
	logic [63:0] cart_id;
	logic        id_match;
	region_t     hdr_region;

	assign rom_active = dl.download & (dl.index[5:0] <= IDX_ROM_MAX);
	assign dl_start   = rom_active & ~rom_active_q;
	assign dl_done    = ~rom_active & rom_active_q;
	assign rom_wr     = rom_active & dl.wr;
	assign id_wr      = rom_wr & dl.index[IDX_CART_BIT];

	assign id_match = (cart_id == PIER_ID_REPRINT) || (cart_id == PIER_ID_FIRST);

	// Region letter sits in the low byte
	always_comb begin
		if (dl.data[7:0] == "J")
			hdr_region = JP;
		else if (dl.data[7:0] == "U")
			hdr_region = US;
		else
			hdr_region = EU;
	end

	//////////////////////////////////////////////////////////////////////
	// Region request and status flags

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_active_q <= 1'b0;
			region_req   <= JP;
			region_set   <= 1'b0;
			pier_quirk   <= 1'b0;
		end else begin
			rom_active_q <= rom_active;
			if (dl_start) begin // New image, forget the old header
				region_req <= JP;
				region_set <= 1'b0;
				pier_quirk <= 1'b0;
			end
			if (dl_done)
				region_set <= 1'b0;
			if (rom_wr && dl.addr == HDR_REGION_ADDR) begin
				region_req <= hdr_region;
				if (auto_region)
					region_set <= 1'b1;
			end
			if (id_wr && dl.addr == HDR_ID_ADDR_LAST && id_match)
				pier_quirk <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ID capture, bytes swapped back into string order

	always_ff @(posedge clk_sys) begin
		if (id_wr) begin
			case (dl.addr)
				HDR_ID_ADDR_FIRST:          cart_id[63:56] <= dl.data[15:8];
				HDR_ID_ADDR_FIRST + 25'd2: cart_id[55:40] <= {dl.data[7:0], dl.data[15:8]};
				HDR_ID_ADDR_FIRST + 25'd4: cart_id[39:24] <= {dl.data[7:0], dl.data[15:8]};
				HDR_ID_ADDR_FIRST + 25'd6: cart_id[23:8]  <= {dl.data[7:0], dl.data[15:8]};
				HDR_ID_ADDR_FIRST + 25'd8: cart_id[7:0]   <= dl.data[7:0]; // Last char
				default: ;
			endcase
		end
	end

endmodule

/* rtl/cart_loader_top.sv */
//////////////////////////////////////////////////////////////////////
// Cartridge loading block of the console core.
// The download stream and the page port are both in the clk_sys domain.
// Bank layout parameters are set here and passed to the mapper.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cart_loader_top import loader_pkg::*, mapper_pkg::*; #(
	parameter int NUM_BANKS    = 8,
	parameter int BANK_SEL_LSB = 19  // Lowest CPU address bit of the bank select
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  dl_stream_t dl,
	input  logic       auto_region,
	input  page_wr_t   page,
	input  rom_addr_t  cpu_va,
	output region_t    region_req,
	output logic       region_set,
	output logic       pier_quirk,
	output logic       cart_mode,
	output rom_mask_t  rom_mask,
	output rom_addr_t  rom_va
);

	logic rom_loading;

	cart_header_scan u_header_scan (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.auto_region (auto_region),
		.region_req  (region_req),
		.region_set  (region_set),
		.pier_quirk  (pier_quirk)
	);

	rom_size_track u_size_track (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.cart_mode   (cart_mode),
		.rom_mask    (rom_mask),
		.rom_loading (rom_loading)
	);

	bank_mapper #(
		.NUM_BANKS    (NUM_BANKS),
		.BANK_SEL_LSB (BANK_SEL_LSB)
	) u_bank_mapper (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.page        (page),
		.cpu_va      (cpu_va),
		.rom_mask    (rom_mask),
		.pier_quirk  (pier_quirk),
		.rom_loading (rom_loading),
		.rom_va      (rom_va)
	);

endmodule

/* rtl/loader_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Download stream types and cartridge header constants.
// Addresses are byte addresses of the 16-bit word stream.
// The low byte of each word comes first in the file.
//////////////////////////////////////////////////////////////////////

package loader_pkg;

	// One cycle of the host download bus
	typedef struct packed {
		logic        download; // High for the whole transfer
		logic        wr;       // One-cycle write strobe
		logic [7:0]  index;    // File index
		logic [24:0] addr;     // Byte address
		logic [15:0] data;     // Word, low byte first in file
	} dl_stream_t;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Index decode
	parameter logic [5:0] IDX_ROM_MAX  = 6'd1; // Compared against index[5:0]
	parameter int         IDX_CART_BIT = 6;    // Set for cartridge, clear for BIOS

	// Header offsets
	parameter logic [24:0] HDR_REGION_ADDR   = 25'h1F0;
	parameter logic [24:0] HDR_ID_ADDR_FIRST = 25'h182;
	parameter logic [24:0] HDR_ID_ADDR_LAST  = 25'h18C;

	// Pier Solar product codes
	parameter logic [63:0] PIER_ID_REPRINT = "T-574023";
	parameter logic [63:0] PIER_ID_FIRST   = "T-574013";

	// ROM size mask covers address bits 23..13
	parameter int MASK_LO = 13;
	parameter int MASK_HI = 23;
	typedef logic [MASK_HI:MASK_LO] rom_mask_t;

endpackage

/* rtl/mapper_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Page port and bank mapper types.
// Page offsets are word offsets, CPU address bits 3..1.
//////////////////////////////////////////////////////////////////////

package mapper_pkg;

	// One page-port access from the CPU side
	typedef struct packed {
		logic        strobe; // Pulse at falling edge of page CE
		logic        rnw;    // High for a read
		logic [2:0]  va;     // Word offset, bits 3..1
		logic [15:0] wdata;
	} page_wr_t;

	// Word address, bits 23..1
	typedef logic [23:1] rom_addr_t;

	// Field widths of the two register layouts
	parameter int BANK_FIELD_W = 5; // Large-ROM layout
	parameter int PIER_FIELD_W = 4; // Pier layout

	typedef logic [BANK_FIELD_W-1:0] bank_t;

	//////////////////////////////////////////////////////////////////////
	// Page offsets

	// EEPROM port on Pier boards, writes here do not touch the banks
	parameter logic [2:0] PAGE_PIER_EEPROM = 3'd4;

endpackage

/* rtl/rom_size_track.sv */
//////////////////////////////////////////////////////////////////////
// Builds the ROM size mask from the download addresses.
// Only cartridge images touch the mask. A write to address 0 restarts it.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rom_size_track import loader_pkg::*; (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  dl_stream_t dl,
	output logic       cart_mode,
	output rom_mask_t  rom_mask,
	output logic       rom_loading
);

	logic rom_wr;
	logic is_cart;

	assign rom_loading = dl.download & (dl.index[5:0] <= IDX_ROM_MAX);
	assign rom_wr      = rom_loading & dl.wr;
	assign is_cart     = dl.index[IDX_CART_BIT];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_mode <= 1'b0;
			rom_mask  <= '0;
		end else if (rom_wr) begin
			cart_mode <= is_cart;
			if (is_cart) begin
				// First word of the image starts a fresh mask
				if (dl.addr == '0)
					rom_mask <= '0;
				else
					rom_mask <= rom_mask | dl.addr[MASK_HI:MASK_LO];
			end
		end
	end

endmodule

/* tests/tb_cart_loader.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the cartridge loading block.
// Images are sparse: header words 0x000..0x1FE, then one top word.
// The ID serial sits at bytes 0x183..0x18A, the region letter at 0x1F0.
// Stops at the first mismatch.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cart_loader import loader_pkg::*, mapper_pkg::*; ();

	localparam int CLK_PERIOD      = 10;
	localparam int WR_SPACING      = 3;   // Write pulse plus two idle cycles
	localparam int WORDS_PER_IMAGE = 257; // 256 header words and the top word
	localparam int NUM_IMAGES      = 8;
	localparam int TIMEOUT_CYCLES  = 2 * NUM_IMAGES * WORDS_PER_IMAGE * WR_SPACING;

	localparam logic [7:0] IDX_CART = 8'h40;
	localparam logic [7:0] IDX_BIOS = 8'h00;

	logic       clk_sys;
	logic       arst_n;
	dl_stream_t dl;
	logic       auto_region;
	page_wr_t   page;
	rom_addr_t  cpu_va;
	region_t    region_req;
	logic       region_set;
	logic       pier_quirk;
	logic       cart_mode;
	rom_mask_t  rom_mask;
	rom_addr_t  rom_va;

	integer    seed = 75;
	rom_mask_t exp_mask;     // Expected size mask
	rom_mask_t image_mask;   // Mask of the last image streamed
	bank_t     exp_bank [8]; // Expected bank registers

	cart_loader_top #(
		.NUM_BANKS    (8),
		.BANK_SEL_LSB (19)
	) UUT (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.auto_region (auto_region),
		.page        (page),
		.cpu_va      (cpu_va),
		.region_req  (region_req),
		.region_set  (region_set),
		.pier_quirk  (pier_quirk),
		.cart_mode   (cart_mode),
		.rom_mask    (rom_mask),
		.rom_va      (rom_va)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		report_failure("timeout, the tests did not finish in time");
	end

	//////////////////////////////////////////////////////////////////////
	// Error reporting and compare tasks

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_region(input string name, input region_t got, input region_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_mask(input string name, input rom_mask_t got, input rom_mask_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
		if (got !== exp)
			report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference models and stimulus helpers

	function automatic logic [7:0] header_byte(input int a, input logic [63:0] id,
			input logic [7:0] letter, input logic [7:0] fill);
		if (a >= 'h183 && a <= 'h18A)
			return id[63 - 8 * (a - 'h183) -: 8]; // First char at 0x183
		else if (a == 'h1F0)
			return letter;
		else
			return fill;
	endfunction

	// Bank on top of the in-window offset, then the size mask
	function automatic rom_addr_t expect_va(input bank_t bank, input rom_addr_t va,
			input rom_mask_t mask);
		rom_addr_t r;
		r = {bank, va[18:1]};
		r[23:13] = r[23:13] & mask;
		return r;
	endfunction

	task automatic write_word(input logic [7:0] index, input logic [24:0] addr,
			input logic [15:0] data);
		@(posedge clk_sys);
		dl.download <= 1'b1;
		dl.wr       <= 1'b1;
		dl.index    <= index;
		dl.addr     <= addr;
		dl.data     <= data;
		if (addr == '0)
			image_mask = '0; // Address 0 restarts the mask
		else
			image_mask = image_mask | addr[23:13];
		@(posedge clk_sys);
		dl.wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	// Download stays high on return
	task automatic download_rom(input logic [7:0] index, input logic [63:0] id,
			input logic [7:0] letter, input logic [24:0] top_addr);
		logic [15:0] fill;
		logic [15:0] word;
		for (int a = 0; a < 'h200; a += 2) begin
			fill = 16'($random(seed));
			word[7:0]  = header_byte(a, id, letter, fill[7:0]);
			word[15:8] = header_byte(a + 1, id, letter, fill[15:8]);
			write_word(index, 25'(a), word);
		end
		fill = 16'($random(seed));
		write_word(index, top_addr, fill);
	endtask

	task automatic finish_download();
		@(posedge clk_sys);
		dl.download <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		for (int n = 0; n < 8; n++)
			exp_bank[n] = bank_t'(n); // Loading restores the identity map
	endtask

	task automatic page_write(input logic [2:0] va, input logic [15:0] data);
		@(posedge clk_sys);
		page.strobe <= 1'b1;
		page.rnw    <= 1'b0;
		page.va     <= va;
		page.wdata  <= data;
		@(posedge clk_sys);
		page.strobe <= 1'b0;
	endtask

	// One random address in each of the eight windows
	task automatic check_windows();
		rom_addr_t va;
		for (int w = 0; w < 8; w++) begin
			va = rom_addr_t'($random(seed));
			va[21:19] = 3'(w);
			@(posedge clk_sys);
			cpu_va <= va;
			@(negedge clk_sys);
			check_addr($sformatf("rom_va window %0d", w), rom_va,
				expect_va(exp_bank[w], va, exp_mask));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic run_region_case(input logic [7:0] letter, input logic auto,
			input region_t exp);
		@(posedge clk_sys);
		auto_region <= auto;
		download_rom(IDX_CART, "T-000000", letter, 25'h07FFFE);
		@(negedge clk_sys);
		check_region("region_req", region_req, exp);
		check_bit("region_set", region_set, auto);
		finish_download();
		exp_mask = image_mask;
		check_bit("region_set", region_set, 1'b0); // Drops with the download
	endtask

	task automatic test_region();
		run_region_case("U", 1'b1, US);
		run_region_case("J", 1'b1, JP);
		run_region_case("E", 1'b0, EU);
	endtask

	task automatic test_cart_id();
		download_rom(IDX_CART, "T-574013", "U", 25'h0FFFFE);
		finish_download();
		exp_mask = image_mask;
		check_bit("pier_quirk", pier_quirk, 1'b1);
		download_rom(IDX_CART, "T-574012", "U", 25'h0FFFFE);
		finish_download();
		exp_mask = image_mask;
		check_bit("pier_quirk", pier_quirk, 1'b0);
	endtask

	task automatic test_size_mask();
		download_rom(IDX_CART, "T-000000", "E", 25'h5A3000);
		finish_download();
		exp_mask = image_mask;
		check_bit("cart_mode", cart_mode, 1'b1);
		check_mask("rom_mask", rom_mask, exp_mask);
		download_rom(IDX_BIOS, "T-000000", "E", 25'h01FFFE);
		finish_download();
		check_bit("cart_mode", cart_mode, 1'b0);
		check_mask("rom_mask", rom_mask, exp_mask); // BIOS keeps the cart mask
	endtask

	task automatic test_large_rom();
		if (!exp_mask[22])
			report_failure("size mask has no bit 22, large-ROM banking cannot be tested");
		page_write(3'd3, 16'h0009);
		exp_bank[3] = 5'd9;
		check_windows();
		page_write(3'd0, 16'h0007); // No register behind offset 0
		check_windows();
	endtask

	task automatic test_pier_banking();
		download_rom(IDX_CART, "T-574023", "J", 25'hFFFFFE); // Mask keeps bit 23
		finish_download();
		exp_mask = image_mask;
		check_bit("pier_quirk", pier_quirk, 1'b1);
		check_windows();
		page_write(3'd2, 16'h001F);
		exp_bank[6] = 5'h0F; // Four bits wide in this layout
		check_windows();
		page_write(3'd4, 16'h0003);
		check_windows();
	endtask

	initial begin
		arst_n      = 1'b0;
		dl          = '0;
		auto_region = 1'b0;
		page        = '0;
		cpu_va      = '0;
		exp_mask    = '0;
		image_mask  = '0;
		for (int n = 0; n < 8; n++)
			exp_bank[n] = bank_t'(n);
		repeat (8) @(posedge clk_sys);
		arst_n <= 1'b1;
		@(negedge clk_sys);
		check_bit("region_set", region_set, 1'b0);
		check_bit("pier_quirk", pier_quirk, 1'b0);
		check_mask("rom_mask", rom_mask, '0);

		test_region();
		test_cart_id();
		test_size_mask();
		check_windows(); // Identity map after the downloads
		test_large_rom();
		test_pier_banking();

		$display("TEST OK");
		$finish;
	end

endmodule

/* vlog.f */
rtl/loader_pkg.sv
rtl/mapper_pkg.sv
rtl/cart_header_scan.sv
rtl/rom_size_track.sv
rtl/bank_mapper.sv
rtl/cart_loader_top.sv
tests/tb_cart_loader.sv
